// File: logic/bp_config.svh
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// word pc width
`define BP_ADDR_BITS 30

// 64-entry direction, kind and target tables
`define BP_INDEX_BITS 6

// gshare history, same length as the index
`define BP_HIST_BITS `BP_INDEX_BITS

// return address stack entries
`define BP_RAS_DEPTH 8

// bimodal and gshare
`define BP_DIR_TABLES 2

// apb byte address
`define BP_APB_ADDR_BITS 8

`endif

// File: logic/bp_pkg.sv
package bp_pkg;

    // branch kind as carried from decode and execute
    typedef enum logic [2:0] {
        BR_NONE     = 3'd0,
        BR_COND     = 3'd1,
        BR_JUMP     = 3'd2,
        BR_CALL     = 3'd3,
        BR_RET      = 3'd4,
        BR_INDIRECT = 3'd5,
        BR_OTHER    = 3'd6
    } bp_kind_e;

    // upper bit set means taken
    typedef logic [1:0] bp_ctr_t;

    // weakly not-taken
    localparam bp_ctr_t CTR_RESET = 2'b01;

    // kinds whose direction comes from the counter tables
    function automatic logic is_cond(bp_kind_e kind);
        return (kind == BR_COND) || (kind == BR_OTHER);
    endfunction

endpackage

// File: logic/bp_index_hash.sv
`timescale 1ns/100ps
`include "bp_config.svh"

module bp_index_hash (
    input  logic [`BP_ADDR_BITS-1:0]                       pc,
    input  logic [`BP_ADDR_BITS-1:0]                       pc_ex,
    input  logic [`BP_HIST_BITS-1:0]                       hist,
    output logic [`BP_DIR_TABLES-1:0][`BP_INDEX_BITS-1:0]  fetch_idx,
    output logic [`BP_DIR_TABLES-1:0][`BP_INDEX_BITS-1:0]  update_idx,
    output logic [`BP_INDEX_BITS-1:0]                      pc_idx,
    output logic [`BP_INDEX_BITS-1:0]                      pc_ex_idx
);

    // fold two index-wide slices of the pc
    function automatic logic [`BP_INDEX_BITS-1:0] fold(logic [`BP_ADDR_BITS-1:0] addr);
        return addr[`BP_INDEX_BITS-1:0] ^ addr[2*`BP_INDEX_BITS-1:`BP_INDEX_BITS];
    endfunction

    assign pc_idx    = fold(pc);
    assign pc_ex_idx = fold(pc_ex);

    // table 0 is plain bimodal, the rest see the global history
    always_comb begin
        for (int t = 0; t < `BP_DIR_TABLES; t++) begin
            if (t == 0) begin
                fetch_idx[t]  = pc_idx;
                update_idx[t] = pc_ex_idx;
            end else begin
                fetch_idx[t]  = pc_idx ^ hist;
                update_idx[t] = pc_ex_idx ^ hist;
            end
        end
    end

endmodule

// File: logic/bp_counter_table.sv
`timescale 1ns/100ps
`include "bp_config.svh"

module bp_counter_table
    import bp_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [`BP_INDEX_BITS-1:0]  fetch_idx,
    input  logic [`BP_INDEX_BITS-1:0]  update_idx,
    input  logic                       wr_en,
    input  bp_ctr_t                    wr_ctr,
    output bp_ctr_t                    fetch_ctr,
    output bp_ctr_t                    update_ctr
);

    localparam int ENTRIES = 1 << `BP_INDEX_BITS;

    bp_ctr_t ctr [ENTRIES];

    // prediction side
    assign fetch_ctr = ctr[fetch_idx];

    // old value for the saturating step at commit
    assign update_ctr = ctr[update_idx];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr[i] <= CTR_RESET;
            end
        end else if (wr_en) begin
            ctr[update_idx] <= wr_ctr;
        end
    end

endmodule

// File: logic/bp_direction_select.sv
`timescale 1ns/100ps
`include "bp_config.svh"

module bp_direction_select
    import bp_pkg::*;
(
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             update_en,
    input  bp_kind_e                         kind_pdc,
    input  bp_kind_e                         kind_ex,
    input  logic                             taken_real,
    input  logic [`BP_INDEX_BITS-1:0]        pc_idx,
    input  logic [`BP_INDEX_BITS-1:0]        pc_ex_idx,
    input  bp_ctr_t [`BP_DIR_TABLES-1:0]     fetch_ctr,
    input  bp_ctr_t [`BP_DIR_TABLES-1:0]     update_ctr,
    output logic                             taken_pdc,
    output logic                             choice_dir,
    output logic [`BP_DIR_TABLES-1:0]        wr_en,
    output bp_ctr_t [`BP_DIR_TABLES-1:0]     wr_ctr
);

    localparam int ENTRIES = 1 << `BP_INDEX_BITS;

    bp_ctr_t chooser [ENTRIES];
    logic    cond_update;
    logic    bim_ok;
    logic    gsh_ok;

    function automatic bp_ctr_t sat_step(bp_ctr_t c, logic up);
        if (up) begin
            return (c == 2'b11) ? c : c + 2'd1;
        end
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    assign cond_update = update_en && is_cond(kind_ex);

    always_comb begin
        for (int t = 0; t < `BP_DIR_TABLES; t++) begin
            wr_en[t]  = cond_update;
            wr_ctr[t] = sat_step(update_ctr[t], taken_real);
        end
    end

    // chooser upper bit set selects gshare
    assign choice_dir = chooser[pc_idx][1];

    always_comb begin
        case (kind_pdc)
            BR_NONE:          taken_pdc = 1'b0;
            BR_COND, BR_OTHER: taken_pdc = fetch_ctr[choice_dir][1];
            default:          taken_pdc = 1'b1;
        endcase
    end

    assign bim_ok = (update_ctr[0][1] == taken_real);
    assign gsh_ok = (update_ctr[1][1] == taken_real);

    // train only when exactly one table was right
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                chooser[i] <= CTR_RESET;
            end
        end else if (cond_update && (bim_ok != gsh_ok)) begin
            chooser[pc_ex_idx] <= sat_step(chooser[pc_ex_idx], gsh_ok);
        end
    end

endmodule

// File: logic/bp_target.sv
`timescale 1ns/100ps
`include "bp_config.svh"

module bp_target
    import bp_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [`BP_ADDR_BITS-1:0]   pc,
    input  logic [`BP_INDEX_BITS-1:0]  pc_idx,
    input  logic [`BP_ADDR_BITS-1:0]   pc_ex,
    input  logic [`BP_INDEX_BITS-1:0]  pc_ex_idx,
    input  logic                       update_en,
    input  bp_kind_e                   kind_ex,
    input  logic                       taken_real,
    input  logic [`BP_ADDR_BITS-1:0]   npc_ex,
    input  logic                       taken_pdc,
    output bp_kind_e                   kind_pdc,
    output logic [`BP_ADDR_BITS-1:0]   npc_pdc,
    output logic                       choice_tgt
);

    localparam int ENTRIES  = 1 << `BP_INDEX_BITS;
    localparam int PTR_BITS = $clog2(`BP_RAS_DEPTH);

    bp_kind_e                   kind_tab [ENTRIES];
    logic [`BP_ADDR_BITS-1:0]   btb [ENTRIES];
    logic [`BP_ADDR_BITS-1:0]   ras [`BP_RAS_DEPTH];
    logic [PTR_BITS-1:0]        ras_ptr;
    logic [PTR_BITS-1:0]        ras_top_ptr;
    logic                       kind_wr;
    logic                       is_ret;

    // ras_ptr is the next free slot
    assign ras_top_ptr = ras_ptr - 1'b1;

    assign kind_pdc   = kind_tab[pc_idx];
    assign is_ret     = (kind_pdc == BR_RET);
    assign choice_tgt = taken_pdc && is_ret;

    always_comb begin
        if (!taken_pdc) begin
            npc_pdc = pc + 1'b1;
        end else if (is_ret) begin
            npc_pdc = ras[ras_top_ptr];
        end else begin
            npc_pdc = btb[pc_idx];
        end
    end

    assign kind_wr = update_en && (kind_ex != BR_NONE);

    // tagless kind table
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                kind_tab[i] <= BR_NONE;
            end
        end else if (kind_wr) begin
            kind_tab[pc_ex_idx] <= kind_ex;
        end
    end

    // btb holds the last taken target
    always_ff @(posedge clk) begin
        if (kind_wr && taken_real) begin
            btb[pc_ex_idx] <= npc_ex;
        end
    end

    // circular stack, overflow drops the oldest
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ras_ptr <= '0;
        end else if (update_en && (kind_ex == BR_CALL)) begin
            ras_ptr <= ras_ptr + 1'b1;
        end else if (update_en && (kind_ex == BR_RET)) begin
            ras_ptr <= ras_top_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (update_en && (kind_ex == BR_CALL)) begin
            ras[ras_ptr] <= pc_ex + 1'b1;
        end
    end

endmodule

// File: logic/bp_history.sv
`timescale 1ns/100ps
`include "bp_config.svh"

module bp_history
    import bp_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       update_en,
    input  bp_kind_e                   kind_ex,
    input  logic                       taken_real,
    output logic [`BP_HIST_BITS-1:0]   hist
);

    // committed outcomes only, newest in bit 0
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hist <= '0;
        end else if (update_en && is_cond(kind_ex)) begin
            hist <= {hist[`BP_HIST_BITS-2:0], taken_real};
        end
    end

endmodule

// File: logic/bp_stats_apb.sv
`timescale 1ns/100ps
`include "bp_config.svh"

module bp_stats_apb
    import bp_pkg::*;
(
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           update_en,
    input  bp_kind_e                       kind_ex,
    input  logic                           mis_taken,
    input  logic                           mis_kind,
    input  logic                           mis_npc,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [`BP_APB_ADDR_BITS-1:0]   paddr,
    input  logic [31:0]                    pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr
);

    localparam int NUM_CNT = 5;

    logic [31:0]         cnt [NUM_CNT];
    logic [NUM_CNT-1:0]  inc;
    logic                access;
    logic                in_range;
    logic                clr;

    // 0x00 updates, 0x04 cond, 0x08 taken, 0x0c kind, 0x10 npc
    assign inc[0] = update_en;
    assign inc[1] = update_en && is_cond(kind_ex);
    assign inc[2] = update_en && mis_taken;
    assign inc[3] = update_en && mis_kind;
    assign inc[4] = update_en && mis_npc;

    assign access   = psel && penable;
    assign in_range = (paddr < `BP_APB_ADDR_BITS'h14);

    // write to 0x00 clears every counter
    assign clr = access && pwrite && (paddr == '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                cnt[i] <= '0;
            end
        end else if (clr) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CNT; i++) begin
                if (inc[i]) begin
                    cnt[i] <= cnt[i] + 32'd1;
                end
            end
        end
    end

    // zero-wait slave
    assign pready  = 1'b1;
    assign pslverr = access && !in_range;

    always_comb begin
        prdata = '0;
        if (access && !pwrite && in_range) begin
            prdata = cnt[paddr[4:2]];
        end
    end

endmodule

// File: logic/bp_predictor.sv
`timescale 1ns/100ps
`include "bp_config.svh"

module bp_predictor
    import bp_pkg::*;
(
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [`BP_ADDR_BITS-1:0]       pc,
    input  logic                           update_en,
    input  logic [`BP_ADDR_BITS-1:0]       pc_ex,
    input  bp_kind_e                       kind_ex,
    input  logic                           taken_real,
    input  logic [`BP_ADDR_BITS-1:0]       npc_ex,
    input  logic                           mis_npc,
    input  logic                           mis_kind,
    input  logic                           mis_taken,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [`BP_APB_ADDR_BITS-1:0]   paddr,
    input  logic [31:0]                    pwdata,
    output bp_kind_e                       kind_pdc,
    output logic                           taken_pdc,
    output logic [`BP_ADDR_BITS-1:0]       npc_pdc,
    output logic                           choice_dir,
    output logic                           choice_tgt,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr
);

    logic [`BP_HIST_BITS-1:0]                       hist;
    logic [`BP_INDEX_BITS-1:0]                      pc_idx;
    logic [`BP_INDEX_BITS-1:0]                      pc_ex_idx;
    logic [`BP_DIR_TABLES-1:0][`BP_INDEX_BITS-1:0]  fetch_idx;
    logic [`BP_DIR_TABLES-1:0][`BP_INDEX_BITS-1:0]  update_idx;
    bp_ctr_t [`BP_DIR_TABLES-1:0]                   fetch_ctr;
    bp_ctr_t [`BP_DIR_TABLES-1:0]                   update_ctr;
    logic [`BP_DIR_TABLES-1:0]                      wr_en;
    bp_ctr_t [`BP_DIR_TABLES-1:0]                   wr_ctr;

    bp_index_hash i_hash (
        .pc         (pc),
        .pc_ex      (pc_ex),
        .hist       (hist),
        .fetch_idx  (fetch_idx),
        .update_idx (update_idx),
        .pc_idx     (pc_idx),
        .pc_ex_idx  (pc_ex_idx)
    );

    // table 0 bimodal, table 1 gshare
    for (genvar t = 0; t < `BP_DIR_TABLES; t++) begin : g_table
        bp_counter_table i_table (
            .clk        (clk),
            .rstn       (rstn),
            .fetch_idx  (fetch_idx[t]),
            .update_idx (update_idx[t]),
            .wr_en      (wr_en[t]),
            .wr_ctr     (wr_ctr[t]),
            .fetch_ctr  (fetch_ctr[t]),
            .update_ctr (update_ctr[t])
        );
    end

    bp_direction_select i_dir (
        .clk        (clk),
        .rstn       (rstn),
        .update_en  (update_en),
        .kind_pdc   (kind_pdc),
        .kind_ex    (kind_ex),
        .taken_real (taken_real),
        .pc_idx     (pc_idx),
        .pc_ex_idx  (pc_ex_idx),
        .fetch_ctr  (fetch_ctr),
        .update_ctr (update_ctr),
        .taken_pdc  (taken_pdc),
        .choice_dir (choice_dir),
        .wr_en      (wr_en),
        .wr_ctr     (wr_ctr)
    );

    bp_target i_target (
        .clk        (clk),
        .rstn       (rstn),
        .pc         (pc),
        .pc_idx     (pc_idx),
        .pc_ex      (pc_ex),
        .pc_ex_idx  (pc_ex_idx),
        .update_en  (update_en),
        .kind_ex    (kind_ex),
        .taken_real (taken_real),
        .npc_ex     (npc_ex),
        .taken_pdc  (taken_pdc),
        .kind_pdc   (kind_pdc),
        .npc_pdc    (npc_pdc),
        .choice_tgt (choice_tgt)
    );

    bp_history i_history (
        .clk        (clk),
        .rstn       (rstn),
        .update_en  (update_en),
        .kind_ex    (kind_ex),
        .taken_real (taken_real),
        .hist       (hist)
    );

    bp_stats_apb i_stats (
        .clk        (clk),
        .rstn       (rstn),
        .update_en  (update_en),
        .kind_ex    (kind_ex),
        .mis_taken  (mis_taken),
        .mis_kind   (mis_kind),
        .mis_npc    (mis_npc),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr)
    );

endmodule

// File: testbench/tb_bp.sv
`timescale 1ns/100ps
`include "bp_config.svh"

module tb_bp
    import bp_pkg::*;
();

    localparam int AW = `BP_ADDR_BITS;
    localparam int IW = `BP_INDEX_BITS;
    localparam int AD = `BP_APB_ADDR_BITS;
    localparam int ENTRIES = 1 << IW;
    localparam int DEPTH = `BP_RAS_DEPTH;
    localparam int NUM_STATS = 5;
    // rough count of stimulus cycles over all tests
    localparam int TEST_CYCLES = 200;
    localparam logic [AD-1:0] REG_END = 'h14;

    logic           clk = 1'b0;
    logic           rstn;
    logic [AW-1:0]  pc;
    logic           update_en;
    logic [AW-1:0]  pc_ex;
    bp_kind_e       kind_ex;
    logic           taken_real;
    logic [AW-1:0]  npc_ex;
    logic           mis_npc;
    logic           mis_kind;
    logic           mis_taken;
    logic           psel;
    logic           penable;
    logic           pwrite;
    logic [AD-1:0]  paddr;
    logic [31:0]    pwdata;
    bp_kind_e       kind_pdc;
    logic           taken_pdc;
    logic [AW-1:0]  npc_pdc;
    logic           choice_dir;
    logic           choice_tgt;
    logic [31:0]    prdata;
    logic           pready;
    logic           pslverr;

    // expected responses, set together with the stimulus
    logic           check_pred;
    bp_kind_e       exp_kind;
    logic           exp_taken;
    logic [AW-1:0]  exp_npc;
    logic           exp_dir;
    logic           exp_tgt;
    logic [31:0]    exp_rdata;
    logic           exp_slverr;

    // reference model
    bp_kind_e                  kind_m [ENTRIES];
    logic [AW-1:0]             btb_m [ENTRIES];
    bp_ctr_t                   bim_m [ENTRIES];
    bp_ctr_t                   gsh_m [ENTRIES];
    bp_ctr_t                   cho_m [ENTRIES];
    logic [`BP_HIST_BITS-1:0]  hist_m;
    bit                        used [ENTRIES];
    logic [AW-1:0]             ras_m [DEPTH];
    int                        ras_ptr_m;
    logic [31:0]               stat_m [NUM_STATS];

    bp_predictor i_dut (.*);

    always #10 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    a_kind: assert property (@(posedge clk) disable iff (!rstn) check_pred |-> kind_pdc == exp_kind)
        else report_failure($sformatf("ERROR kind_pdc: got %h, expected %h",
                                      $sampled(kind_pdc), $sampled(exp_kind)));
    a_taken: assert property (@(posedge clk) disable iff (!rstn)
                              check_pred |-> taken_pdc == exp_taken)
        else report_failure($sformatf("ERROR taken_pdc: got %h, expected %h",
                                      $sampled(taken_pdc), $sampled(exp_taken)));
    a_npc: assert property (@(posedge clk) disable iff (!rstn) check_pred |-> npc_pdc == exp_npc)
        else report_failure($sformatf("ERROR npc_pdc: got %h, expected %h",
                                      $sampled(npc_pdc), $sampled(exp_npc)));
    a_dir: assert property (@(posedge clk) disable iff (!rstn)
                            check_pred |-> choice_dir == exp_dir)
        else report_failure($sformatf("ERROR choice_dir: got %h, expected %h",
                                      $sampled(choice_dir), $sampled(exp_dir)));
    a_tgt: assert property (@(posedge clk) disable iff (!rstn)
                            check_pred |-> choice_tgt == exp_tgt)
        else report_failure($sformatf("ERROR choice_tgt: got %h, expected %h",
                                      $sampled(choice_tgt), $sampled(exp_tgt)));
    a_rdata: assert property (@(posedge clk) disable iff (!rstn) prdata == exp_rdata)
        else report_failure($sformatf("ERROR prdata: got %h, expected %h",
                                      $sampled(prdata), $sampled(exp_rdata)));
    a_slverr: assert property (@(posedge clk) disable iff (!rstn) pslverr == exp_slverr)
        else report_failure($sformatf("ERROR pslverr: got %h, expected %h",
                                      $sampled(pslverr), $sampled(exp_slverr)));
    a_ready: assert property (@(posedge clk) disable iff (!rstn) (psel && penable) |-> pready)
        else report_failure("pready was low during an APB access phase");

    // index equals the low pc bits when the next slice is zero
    function automatic logic [AW-1:0] make_pc(input logic [IW-1:0] idx);
        logic [AW-1:0] a;
        a = AW'($urandom);
        a[2*IW-1:IW] = '0;
        a[IW-1:0] = idx;
        return a;
    endfunction

    function automatic logic [IW-1:0] fresh_idx();
        logic [IW-1:0] idx;
        idx = IW'($urandom);
        while (used[idx]) begin
            idx = idx + 1'b1;
        end
        used[idx] = 1'b1;
        return idx;
    endfunction

    // one saturating step of a 2-bit counter toward the outcome
    function automatic bp_ctr_t train_counter(input bp_ctr_t c, input logic up);
        int v;
        v = up ? int'(c) + 1 : int'(c) - 1;
        if (v < 0) begin
            v = 0;
        end else if (v > 3) begin
            v = 3;
        end
        return bp_ctr_t'(v);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
        update_en  = 1'b0;
        check_pred = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        exp_rdata  = '0;
        exp_slverr = 1'b0;
    endtask

    task automatic commit(input logic [AW-1:0] upc, input bp_kind_e kind, input logic taken,
                          input logic [AW-1:0] unpc, input logic [2:0] mis);
        logic [IW-1:0] idx;
        logic [IW-1:0] gidx;
        logic          bim_ok;
        logic          gsh_ok;
        idx = upc[IW-1:0];
        gidx = idx ^ hist_m;
        next_cycle();
        update_en  = 1'b1;
        pc_ex      = upc;
        kind_ex    = kind;
        taken_real = taken;
        npc_ex     = unpc;
        mis_taken  = mis[0];
        mis_kind   = mis[1];
        mis_npc    = mis[2];
        stat_m[0] = stat_m[0] + 32'd1;
        if ((kind == BR_COND) || (kind == BR_OTHER)) begin
            stat_m[1] = stat_m[1] + 32'd1;
            bim_ok = (bim_m[idx][1] == taken);
            gsh_ok = (gsh_m[gidx][1] == taken);
            // chooser learns only when one table alone was right
            if (gsh_ok && !bim_ok) begin
                cho_m[idx] = train_counter(cho_m[idx], 1'b1);
            end else if (bim_ok && !gsh_ok) begin
                cho_m[idx] = train_counter(cho_m[idx], 1'b0);
            end
            bim_m[idx] = train_counter(bim_m[idx], taken);
            gsh_m[gidx] = train_counter(gsh_m[gidx], taken);
            hist_m = {hist_m[`BP_HIST_BITS-2:0], taken};
        end
        for (int i = 0; i < 3; i++) begin
            if (mis[i]) begin
                stat_m[2+i] = stat_m[2+i] + 32'd1;
            end
        end
        if (kind != BR_NONE) begin
            kind_m[idx] = kind;
            if (taken) begin
                btb_m[idx] = unpc;
            end
        end
        if (kind == BR_CALL) begin
            ras_m[ras_ptr_m] = upc + 1'b1;
            ras_ptr_m = (ras_ptr_m + 1) % DEPTH;
        end else if (kind == BR_RET) begin
            ras_ptr_m = (ras_ptr_m + DEPTH - 1) % DEPTH;
        end
    endtask

    task automatic predict(input logic [AW-1:0] fpc);
        logic [IW-1:0] idx;
        logic [IW-1:0] gidx;
        bp_kind_e      k;
        idx = fpc[IW-1:0];
        gidx = idx ^ hist_m;
        k = kind_m[idx];
        next_cycle();
        pc         = fpc;
        check_pred = 1'b1;
        exp_kind   = k;
        exp_dir    = cho_m[idx][1];
        if (k == BR_NONE) begin
            exp_taken = 1'b0;
        end else if ((k == BR_COND) || (k == BR_OTHER)) begin
            exp_taken = exp_dir ? gsh_m[gidx][1] : bim_m[idx][1];
        end else begin
            exp_taken = 1'b1;
        end
        exp_tgt = exp_taken && (k == BR_RET);
        if (!exp_taken) begin
            exp_npc = fpc + 1'b1;
        end else if (k == BR_RET) begin
            exp_npc = ras_m[(ras_ptr_m + DEPTH - 1) % DEPTH];
        end else begin
            exp_npc = btb_m[idx];
        end
    endtask

    task automatic apb_transfer(input logic wr, input logic [AD-1:0] addr,
                                input logic [31:0] wdata);
        int slot;
        slot = int'(addr) / 4;
        next_cycle();
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = wdata;
        @(posedge clk);
        #2;
        penable    = 1'b1;
        exp_slverr = (addr >= REG_END);
        if (!wr && (addr < REG_END)) begin
            exp_rdata = stat_m[slot];
        end
        // clear lands at the end of this access
        if (wr && (addr == '0)) begin
            for (int i = 0; i < NUM_STATS; i++) begin
                stat_m[i] = '0;
            end
        end
    endtask

    task automatic read_counters();
        for (int a = 0; a < NUM_STATS; a++) begin
            apb_transfer(1'b0, AD'(a * 4), 32'd0);
        end
    endtask

    task automatic reset_state();
        for (int i = 0; i < 16; i++) begin
            predict(make_pc(IW'($urandom)));
        end
    endtask

    task automatic train_jumps();
        logic [AW-1:0] jpc;
        for (int i = 0; i < 6; i++) begin
            jpc = make_pc(fresh_idx());
            commit(jpc, (i % 2 == 0) ? BR_JUMP : BR_INDIRECT, 1'b1, AW'($urandom), 3'b000);
            predict(jpc);
        end
    endtask

    task automatic call_return();
        logic [AW-1:0] cpc;
        logic [AW-1:0] rpc;
        // more calls than the stack holds
        for (int i = 0; i < DEPTH + 4; i++) begin
            cpc = make_pc(fresh_idx());
            commit(cpc, BR_CALL, 1'b1, AW'($urandom), 3'b000);
        end
        predict(cpc);
        rpc = make_pc(fresh_idx());
        for (int i = 0; i < DEPTH + 2; i++) begin
            commit(rpc, BR_RET, 1'b1, AW'($urandom), 3'b000);
            predict(rpc);
        end
        commit(cpc, BR_CALL, 1'b1, AW'($urandom), 3'b000);
        predict(rpc);
    endtask

    task automatic train_conditional();
        logic [IW-1:0] idx;
        logic [AW-1:0] cpc;
        logic [AW-1:0] tgt;
        idx = fresh_idx();
        cpc = make_pc(idx);
        tgt = AW'($urandom);
        repeat (`BP_HIST_BITS + 2) commit(cpc, BR_COND, 1'b1, tgt, 3'b000);
        predict(cpc);
        repeat (`BP_HIST_BITS + 2) commit(cpc, BR_COND, 1'b0, cpc + 1'b1, 3'b000);
        predict(cpc);
    endtask

    task automatic count_statistics();
        for (int i = 0; i < 40; i++) begin
            commit(make_pc(IW'($urandom)), bp_kind_e'($urandom_range(6, 0)), 1'($urandom),
                   AW'($urandom), 3'($urandom));
        end
        read_counters();
        // a write off 0x00 leaves the counters alone
        apb_transfer(1'b1, AD'(8'h08), $urandom);
        read_counters();
    endtask

    task automatic apb_control();
        apb_transfer(1'b1, '0, $urandom);
        read_counters();
        apb_transfer(1'b0, REG_END, 32'd0);
        apb_transfer(1'b1, REG_END, $urandom);
        apb_transfer(1'b0, AD'($urandom_range(255, 20)), 32'd0);
        read_counters();
    endtask

    initial begin
        #((TEST_CYCLES + 200) * 20);
        report_failure("timeout: the tests did not finish in time");
    end

    initial begin
        void'($urandom(32'h39b9));
        rstn = 1'b0;
        pc = '0;
        update_en = 1'b0;
        pc_ex = '0;
        kind_ex = BR_NONE;
        taken_real = 1'b0;
        npc_ex = '0;
        mis_npc = 1'b0;
        mis_kind = 1'b0;
        mis_taken = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        check_pred = 1'b0;
        exp_kind = BR_NONE;
        exp_taken = 1'b0;
        exp_npc = '0;
        exp_dir = 1'b0;
        exp_tgt = 1'b0;
        exp_rdata = '0;
        exp_slverr = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            kind_m[i] = BR_NONE;
            btb_m[i] = '0;
            bim_m[i] = 2'b01;
            gsh_m[i] = 2'b01;
            cho_m[i] = 2'b01;
            used[i] = 1'b0;
        end
        hist_m = '0;
        for (int i = 0; i < DEPTH; i++) begin
            ras_m[i] = '0;
        end
        ras_ptr_m = 0;
        for (int i = 0; i < NUM_STATS; i++) begin
            stat_m[i] = '0;
        end
        repeat (16) @(posedge clk);
        #2;
        rstn = 1'b1;
        reset_state();
        train_jumps();
        call_return();
        train_conditional();
        count_statistics();
        apb_control();
        next_cycle();
        next_cycle();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: tb.f
+incdir+logic
logic/bp_pkg.sv
logic/bp_index_hash.sv
logic/bp_counter_table.sv
logic/bp_direction_select.sv
logic/bp_target.sv
logic/bp_history.sv
logic/bp_stats_apb.sv
logic/bp_predictor.sv
testbench/tb_bp.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f tb.f --top-module tb_bp -o tb_bp
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_bp > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0
